// File: hw/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// First fetch address after reset
`define FETCH_RESET_VECTOR 32'h0000_2000

// Mapped instruction window
`define MEM_BASE 32'h0000_2000
`define MEM_WORDS 64

// WAIT cycles shown before DONE on a fetch
`define MEM_LATENCY 2

// WAIT cycles shown before DONE on a flush
`define MEM_FLUSH_CYCLES 3

`endif

// File: hw/mem_if_pkg.sv
`default_nettype none

package mem_if_pkg;

    // Commands from fetch to the instruction memory port
    typedef enum logic [1:0] {
        CACHE_CMD_NONE,
        CACHE_CMD_EXECUTE,
        CACHE_CMD_FLUSH_ALL
    } cache_cmd_e;

    // Port status, DONE and the fault codes last one cycle
    typedef enum logic [2:0] {
        CACHE_RESP_IDLE,
        CACHE_RESP_WAIT,
        CACHE_RESP_DONE,
        CACHE_RESP_ACCESSFAULT,
        CACHE_RESP_MISALIGNED,
        CACHE_RESP_PAGEFAULT
    } cache_resp_e;

    typedef struct packed {
        cache_cmd_e  cmd;
        logic [31:0] addr;
    } mem_req_t;

    typedef struct packed {
        cache_resp_e resp;
        logic [31:0] load_data;
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: hw/core_pkg.sv
`default_nettype none

package core_pkg;

    // addi x0, x0, 0
    localparam logic [31:0] INSTR_NOP = 32'h0000_0013;

    // RISC-V privilege encodings
    typedef enum logic [1:0] {
        PRIV_USER       = 2'd0,
        PRIV_SUPERVISOR = 2'd1,
        PRIV_MACHINE    = 2'd3
    } priv_e;

    typedef enum logic [1:0] {
        E2F_NONE,
        E2F_BRANCHTAKEN,
        E2F_BUBBLE_BRANCH,
        E2F_FLUSH
    } e2f_cmd_e;

    // Only the fetch related mcause values
    typedef enum logic [31:0] {
        EXC_INSTR_MISALIGNED   = 32'd0,
        EXC_INSTR_ACCESS_FAULT = 32'd1,
        EXC_INSTR_PAGE_FAULT   = 32'd12
    } exc_code_e;

    typedef struct packed {
        logic [31:0] mtvec;
        logic [31:0] stvec;
        priv_e       cur_priv;
        logic [15:0] medeleg;
    } trap_csr_t;

    typedef struct packed {
        logic        pending;
        logic [31:0] cause;
        logic [31:0] target_pc;
        priv_e       target_priv;
    } irq_t;

    typedef struct packed {
        logic        ready;
        e2f_cmd_e    cmd;
        logic [31:0] bubble_branch_target;
        logic [31:0] branch_target;
        logic [31:0] cause;
        priv_e       exc_priv;
    } e2f_t;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic        exc_start;
        logic [31:0] epc;
        logic [31:0] cause;
        priv_e       exc_priv;
    } f2e_t;

    typedef struct packed {
        logic        request;
        logic        set_pc;
        logic        exit_request;
        logic [31:0] pc;
    } dbg_req_t;

endpackage

`default_nettype wire

// File: hw/trap_target.sv
`default_nettype none

module trap_target
    import core_pkg::*;
(
    input  wire trap_csr_t csr,
    input  wire exc_code_e cause,
    output priv_e          priv,
    output logic [31:0]    vector
);

    logic delegated;

    // Delegation only applies when trapping from below machine mode
    always_comb begin
        delegated = 1'b0;
        if (csr.cur_priv != PRIV_MACHINE) begin
            delegated = csr.medeleg[cause[3:0]];
        end
    end

    always_comb begin
        if (delegated) begin
            priv   = PRIV_SUPERVISOR;
            vector = csr.stvec;
        end else begin
            priv   = PRIV_MACHINE;
            vector = csr.mtvec;
        end
    end

    // medeleg is only 16 bits wide here
    always_comb begin
        assert (cause < 32'd16)
            else $error("trap_target: cause %0d outside medeleg", cause);
    end

endmodule

`default_nettype wire

// File: hw/fetch_unit.sv
`default_nettype none

`include "fetch_settings.svh"

module fetch_unit
    import mem_if_pkg::*;
    import core_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire trap_csr_t csr,
    input  wire irq_t      irq,
    input  wire dbg_req_t  dbg,
    input  wire e2f_t      e2f,
    input  wire mem_rsp_t  mem_rsp,
    input  wire logic      mem_reset_done,
    output mem_req_t       mem_req,
    output f2e_t           f2e,
    output logic           dbg_mode,
    output logic           dbg_done
);

    // Control state
    logic [31:0] pc;
    logic        bubble;
    logic        flushing;
    logic        exc_start;

    // Payload
    logic [31:0] exc_epc;
    logic [31:0] exc_cause;
    priv_e       exc_priv;

    logic [31:0] pc_nxt;
    logic        bubble_nxt;
    logic        flushing_nxt;
    logic        dbg_mode_nxt;
    logic        exc_start_nxt;
    logic [31:0] exc_epc_nxt;
    logic [31:0] exc_cause_nxt;
    priv_e       exc_priv_nxt;

    cache_cmd_e  cmd;
    logic [31:0] instr_out;
    logic [31:0] pc_plus_4;
    logic        cache_idle;
    logic        cache_done;
    logic        cache_error;
    logic        new_fetch_begin;
    exc_code_e   fault_cause;
    priv_e       trap_priv;
    logic [31:0] trap_vector;

    assign cache_idle  = mem_rsp.resp == CACHE_RESP_IDLE;
    assign cache_done  = mem_rsp.resp == CACHE_RESP_DONE;
    assign cache_error = (mem_rsp.resp == CACHE_RESP_ACCESSFAULT) ||
                         (mem_rsp.resp == CACHE_RESP_MISALIGNED) ||
                         (mem_rsp.resp == CACHE_RESP_PAGEFAULT);
    assign pc_plus_4   = pc + 32'd4;

    // Word consumed by execute, or leaving debug without a new pc
    assign new_fetch_begin =
        (dbg_mode && dbg.exit_request && !bubble && (cache_idle || cache_done)) ||
        (e2f.ready && (cache_done || cache_error));

    always_comb begin
        case (mem_rsp.resp)
            CACHE_RESP_MISALIGNED: fault_cause = EXC_INSTR_MISALIGNED;
            CACHE_RESP_PAGEFAULT:  fault_cause = EXC_INSTR_PAGE_FAULT;
            default:               fault_cause = EXC_INSTR_ACCESS_FAULT;
        endcase
    end

    trap_target u_trap_target (
        .csr    (csr),
        .cause  (fault_cause),
        .priv   (trap_priv),
        .vector (trap_vector)
    );

    // Word toward execute
    always_comb begin
        instr_out = INSTR_NOP;
        if (mem_reset_done && !dbg_mode) begin
            if (cache_done && !flushing) begin
                instr_out = mem_rsp.load_data;
            end
        end
    end

    always_comb begin
        pc_nxt        = pc;
        bubble_nxt    = bubble;
        flushing_nxt  = flushing;
        dbg_mode_nxt  = dbg_mode;
        exc_start_nxt = 1'b0;
        exc_epc_nxt   = exc_epc;
        exc_cause_nxt = exc_cause;
        exc_priv_nxt  = exc_priv;
        cmd           = CACHE_CMD_NONE;
        dbg_done      = 1'b0;

        if (mem_reset_done) begin
            if (dbg_mode && !dbg.exit_request) begin
                dbg_done = cache_done;
                if (dbg.set_pc) begin
                    pc_nxt     = dbg.pc;
                    bubble_nxt = 1'b1;
                    dbg_done   = 1'b1;
                end
            end else if (flushing) begin
                // Hold FLUSH_ALL until the port reports DONE
                if (cache_done) begin
                    flushing_nxt = 1'b0;
                end else begin
                    cmd = CACHE_CMD_FLUSH_ALL;
                end
            end else if (bubble && cache_idle && e2f.ready) begin
                cmd          = CACHE_CMD_EXECUTE;
                bubble_nxt   = 1'b0;
                dbg_mode_nxt = 1'b0;
            end else if (new_fetch_begin) begin
                dbg_mode_nxt = 1'b0;
                if (dbg.request) begin
                    dbg_mode_nxt = 1'b1;
                end else if (irq.pending) begin
                    bubble_nxt    = 1'b1;
                    pc_nxt        = irq.target_pc;
                    exc_start_nxt = 1'b1;
                    exc_epc_nxt   = pc;
                    exc_cause_nxt = irq.cause;
                    exc_priv_nxt  = irq.target_priv;
                end else if (e2f.cmd == E2F_BUBBLE_BRANCH) begin
                    bubble_nxt    = 1'b1;
                    pc_nxt        = e2f.bubble_branch_target;
                    exc_start_nxt = 1'b1;
                    exc_epc_nxt   = pc;
                    exc_cause_nxt = e2f.cause;
                    exc_priv_nxt  = e2f.exc_priv;
                end else if (e2f.cmd == E2F_FLUSH) begin
                    // Resume after the flushing instruction
                    bubble_nxt   = 1'b1;
                    flushing_nxt = 1'b1;
                    pc_nxt       = pc_plus_4;
                end else if (e2f.cmd == E2F_BRANCHTAKEN) begin
                    pc_nxt = e2f.branch_target;
                    cmd    = CACHE_CMD_EXECUTE;
                end else if (cache_error) begin
                    bubble_nxt    = 1'b1;
                    pc_nxt        = trap_vector;
                    exc_start_nxt = 1'b1;
                    exc_epc_nxt   = pc;
                    exc_cause_nxt = fault_cause;
                    exc_priv_nxt  = trap_priv;
                end else begin
                    pc_nxt = pc_plus_4;
                    cmd    = CACHE_CMD_EXECUTE;
                end
            end else if (cache_idle && !bubble) begin
                // Word not taken so fetch the same pc again
                cmd = CACHE_CMD_EXECUTE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc        <= `FETCH_RESET_VECTOR;
            bubble    <= 1'b1;
            flushing  <= 1'b0;
            dbg_mode  <= 1'b0;
            exc_start <= 1'b0;
        end else begin
            pc        <= pc_nxt;
            bubble    <= bubble_nxt;
            flushing  <= flushing_nxt;
            dbg_mode  <= dbg_mode_nxt;
            exc_start <= exc_start_nxt;
        end
    end

    always_ff @(posedge clk) begin
        exc_epc   <= exc_epc_nxt;
        exc_cause <= exc_cause_nxt;
        exc_priv  <= exc_priv_nxt;
    end

    // Address is always the next pc
    assign mem_req = '{cmd: cmd, addr: pc_nxt};

    assign f2e = '{
        instr:     instr_out,
        pc:        pc,
        exc_start: exc_start,
        epc:       exc_epc,
        cause:     exc_cause,
        exc_priv:  exc_priv
    };

    // No flush may start while debug halts fetch
    assert property (@(posedge clk) disable iff (!rst_n)
        dbg_mode |-> (mem_req.cmd != CACHE_CMD_FLUSH_ALL));

    assert property (@(posedge clk) disable iff (!rst_n)
        exc_start |=> !exc_start);

endmodule

`default_nettype wire

// File: hw/instr_mem_port.sv
`default_nettype none

`include "fetch_settings.svh"

module instr_mem_port
    import mem_if_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire mem_req_t req,
    output mem_rsp_t      rsp,
    output logic          reset_done
);

    localparam int          IDX_W     = $clog2(`MEM_WORDS);
    localparam int          CNT_W     = 4;
    localparam logic [31:0] MEM_END   = `MEM_BASE + 32'(4 * `MEM_WORDS);
    localparam string       INIT_FILE = "bench/program.hex";

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_FLUSH
    } state_e;

    state_e           state;
    logic [CNT_W-1:0] cnt;
    logic [31:0]      addr_q;
    logic [31:0]      mem [`MEM_WORDS];

    logic [31:0]      offset;
    logic [IDX_W-1:0] idx;
    logic             busy;
    logic             accept;
    cache_resp_e      fetch_code;
    cache_resp_e      resp_code;

    initial begin
        $readmemh(INIT_FILE, mem);
    end

    // Counting down means WAIT, zero is the one-cycle result
    assign busy   = (state != ST_IDLE) && (cnt != '0);
    assign accept = reset_done && !busy;

    assign offset = addr_q - `MEM_BASE;
    assign idx    = offset[IDX_W+1:2];

    // Fault order: alignment, then page, then window
    always_comb begin
        if (addr_q[1:0] != 2'b00) begin
            fetch_code = CACHE_RESP_MISALIGNED;
        end else if (addr_q[31]) begin
            fetch_code = CACHE_RESP_PAGEFAULT;
        end else if ((addr_q < `MEM_BASE) || (addr_q >= MEM_END)) begin
            fetch_code = CACHE_RESP_ACCESSFAULT;
        end else begin
            fetch_code = CACHE_RESP_DONE;
        end
    end

    always_comb begin
        case (state)
            ST_FETCH: resp_code = busy ? CACHE_RESP_WAIT : fetch_code;
            ST_FLUSH: resp_code = busy ? CACHE_RESP_WAIT : CACHE_RESP_DONE;
            default:  resp_code = CACHE_RESP_IDLE;
        endcase
    end

    assign rsp = '{resp: resp_code, load_data: mem[idx]};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            cnt        <= '0;
            reset_done <= 1'b0;
        end else begin
            reset_done <= 1'b1;
            if (accept) begin
                case (req.cmd)
                    CACHE_CMD_EXECUTE: begin
                        state <= ST_FETCH;
                        cnt   <= CNT_W'(`MEM_LATENCY);
                    end
                    CACHE_CMD_FLUSH_ALL: begin
                        state <= ST_FLUSH;
                        cnt   <= CNT_W'(`MEM_FLUSH_CYCLES);
                    end
                    default: begin
                        state <= ST_IDLE;
                    end
                endcase
            end else if (busy) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && (req.cmd == CACHE_CMD_EXECUTE)) begin
            addr_q <= req.addr;
        end
    end

    // Only a held flush may be seen while busy
    assert property (@(posedge clk) disable iff (!rst_n)
        (rsp.resp == CACHE_RESP_WAIT) |->
            ((req.cmd == CACHE_CMD_NONE) ||
             ((state == ST_FLUSH) && (req.cmd == CACHE_CMD_FLUSH_ALL))));

endmodule

`default_nettype wire

// File: hw/fetch_subsystem.sv
`default_nettype none

module fetch_subsystem
    import mem_if_pkg::*;
    import core_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire trap_csr_t csr,
    input  wire irq_t      irq,
    input  wire dbg_req_t  dbg,
    input  wire e2f_t      e2f,
    output f2e_t           f2e,
    output logic           dbg_mode,
    output logic           dbg_done,
    output mem_rsp_t       mem_rsp_mon
);

    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    logic     mem_reset_done;

    fetch_unit u_fetch_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .csr            (csr),
        .irq            (irq),
        .dbg            (dbg),
        .e2f            (e2f),
        .mem_rsp        (mem_rsp),
        .mem_reset_done (mem_reset_done),
        .mem_req        (mem_req),
        .f2e            (f2e),
        .dbg_mode       (dbg_mode),
        .dbg_done       (dbg_done)
    );

    instr_mem_port u_instr_mem_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (mem_req),
        .rsp        (mem_rsp),
        .reset_done (mem_reset_done)
    );

    // Response visible outside for monitoring
    assign mem_rsp_mon = mem_rsp;

endmodule

`default_nettype wire

// File: bench/fetch_tb.sv
`default_nettype none

`include "fetch_settings.svh"

module fetch_tb
    import mem_if_pkg::*;
    import core_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // Roughly four times the summed length of all tests
    localparam int          TIMEOUT_CYCLES = 2000;
    localparam logic [31:0] NOP_WORD       = 32'h0000_0013;
    localparam logic [31:0] BASE           = `MEM_BASE;
    localparam logic [31:0] MTVEC          = BASE + 32'h80;
    localparam logic [31:0] STVEC          = BASE + 32'hC0;
    localparam logic [31:0] IRQ_CAUSE      = 32'h8000_0007;

    logic        clk;
    logic        rst_n;
    trap_csr_t   csr;
    irq_t        irq;
    dbg_req_t    dbg;
    e2f_t        e2f;
    f2e_t        f2e;
    logic        dbg_mode;
    logic        dbg_done;
    mem_rsp_t    mem_rsp_mon;

    logic [31:0] model [`MEM_WORDS];
    logic [31:0] exp_pc;
    logic [31:0] last_pc;
    int          errors;
    int          checks;
    int          cycle_count;

    fetch_subsystem DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr         (csr),
        .irq         (irq),
        .dbg         (dbg),
        .e2f         (e2f),
        .f2e         (f2e),
        .dbg_mode    (dbg_mode),
        .dbg_done    (dbg_done),
        .mem_rsp_mon (mem_rsp_mon)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // Inputs change 1 ns after the edge and command pulses last one cycle
    task automatic next_cycle();
        @(posedge clk);
        #1;
        e2f.cmd          = E2F_NONE;
        irq.pending      = 1'b0;
        dbg.request      = 1'b0;
        dbg.set_pc       = 1'b0;
        dbg.exit_request = 1'b0;
    endtask

    task automatic wait_done();
        next_cycle();
        while (mem_rsp_mon.resp != CACHE_RESP_DONE) begin
            next_cycle();
        end
    endtask

    // Word delivered in the current DONE cycle
    task automatic take_word();
        @(negedge clk);
        check_value("f2e.pc", f2e.pc, exp_pc);
        check_value("f2e.instr", f2e.instr, model[(exp_pc - BASE) >> 2]);
        check_value("mem_rsp_mon.load_data", mem_rsp_mon.load_data,
                    model[(exp_pc - BASE) >> 2]);
        last_pc = exp_pc;
        exp_pc  = exp_pc + 32'd4;
    endtask

    // Pulse shows up one cycle after the triggering cycle
    task automatic expect_trap(input logic [31:0] epc, input logic [31:0] cause,
                               input priv_e priv);
        next_cycle();
        @(negedge clk);
        check_value("f2e.exc_start", f2e.exc_start, 1'b1);
        check_value("f2e.epc", f2e.epc, epc);
        check_value("f2e.cause", f2e.cause, cause);
        check_value("f2e.exc_priv", f2e.exc_priv, priv);
        next_cycle();
        @(negedge clk);
        check_value("f2e.exc_start", f2e.exc_start, 1'b0);
    endtask

    task automatic sequential_fetch();
        int i;
        exp_pc = `FETCH_RESET_VECTOR;
        @(negedge clk);
        check_value("f2e.pc", f2e.pc, exp_pc);
        check_value("f2e.exc_start", f2e.exc_start, 1'b0);
        check_value("dbg_mode", dbg_mode, 1'b0);
        check_value("dbg_done", dbg_done, 1'b0);
        for (i = 0; i < 10; i++) begin
            wait_done();
            take_word();
        end
    endtask

    task automatic backpressure_order();
        int taken;
        int stalls;
        taken  = 0;
        stalls = 0;
        // Loop only ends right after a word taken with ready high
        while (taken < 12) begin
            next_cycle();
            e2f.ready = ($urandom % 2) == 0;
            if (mem_rsp_mon.resp == CACHE_RESP_DONE) begin
                if (e2f.ready) begin
                    take_word();
                    taken++;
                end else begin
                    stalls++;
                end
            end else begin
                // Nothing to deliver outside DONE
                @(negedge clk);
                check_value("f2e.instr", f2e.instr, NOP_WORD);
            end
        end
        if (stalls == 0) begin
            errors++;
            $display("Back-pressure test never held back a delivered word");
        end
    endtask

    task automatic branch_and_flush();
        int dones;
        wait_done();
        e2f.cmd           = E2F_BRANCHTAKEN;
        e2f.branch_target = BASE + 32'h40;
        take_word();
        exp_pc = BASE + 32'h40;
        wait_done();
        take_word();
        wait_done();
        e2f.cmd = E2F_FLUSH;
        take_word();
        // Only NOPs until the flush DONE has passed
        dones = 0;
        next_cycle();
        while ((dones == 0) || (mem_rsp_mon.resp != CACHE_RESP_DONE)) begin
            @(negedge clk);
            check_value("f2e.instr", f2e.instr, NOP_WORD);
            if (mem_rsp_mon.resp == CACHE_RESP_DONE) begin
                dones++;
            end
            next_cycle();
        end
        take_word();
    endtask

    task automatic fault_case(input logic [31:0] target, input cache_resp_e code,
                              input priv_e cur_priv, input logic [31:0] cause,
                              input priv_e priv, input logic [31:0] vector);
        wait_done();
        csr.cur_priv      = cur_priv;
        e2f.cmd           = E2F_BRANCHTAKEN;
        e2f.branch_target = target;
        take_word();
        next_cycle();
        while (mem_rsp_mon.resp == CACHE_RESP_WAIT) begin
            next_cycle();
        end
        @(negedge clk);
        check_value("mem_rsp_mon.resp", mem_rsp_mon.resp, code);
        expect_trap(target, cause, priv);
        exp_pc = vector;
        wait_done();
        take_word();
    endtask

    // Only access faults from user delegate with medeleg bit 1
    task automatic fetch_faults();
        fault_case(BASE + 32'd2, CACHE_RESP_MISALIGNED, PRIV_USER,
                   32'd0, PRIV_MACHINE, MTVEC);
        fault_case(32'h8000_0000, CACHE_RESP_PAGEFAULT, PRIV_USER,
                   32'd12, PRIV_MACHINE, MTVEC);
        fault_case(32'h0000_0100, CACHE_RESP_ACCESSFAULT, PRIV_USER,
                   32'd1, PRIV_SUPERVISOR, STVEC);
        fault_case(32'h0000_0100, CACHE_RESP_ACCESSFAULT, PRIV_MACHINE,
                   32'd1, PRIV_MACHINE, MTVEC);
    endtask

    task automatic irq_and_bubble_branch();
        wait_done();
        irq.pending     = 1'b1;
        irq.cause       = IRQ_CAUSE;
        irq.target_pc   = BASE + 32'h20;
        irq.target_priv = PRIV_MACHINE;
        take_word();
        expect_trap(last_pc, IRQ_CAUSE, PRIV_MACHINE);
        exp_pc = BASE + 32'h20;
        wait_done();
        take_word();
        wait_done();
        e2f.cmd                  = E2F_BUBBLE_BRANCH;
        e2f.bubble_branch_target = BASE + 32'h60;
        e2f.cause                = 32'd2;
        e2f.exc_priv             = PRIV_SUPERVISOR;
        take_word();
        expect_trap(last_pc, 32'd2, PRIV_SUPERVISOR);
        exp_pc = BASE + 32'h60;
        wait_done();
        take_word();
    endtask

    task automatic debug_halt_resume();
        int i;
        wait_done();
        dbg.request = 1'b1;
        take_word();
        for (i = 0; i < 4; i++) begin
            next_cycle();
            @(negedge clk);
            check_value("dbg_mode", dbg_mode, 1'b1);
            check_value("dbg_done", dbg_done, 1'b0);
            check_value("f2e.instr", f2e.instr, NOP_WORD);
        end
        next_cycle();
        dbg.set_pc = 1'b1;
        dbg.pc     = BASE + 32'h30;
        @(negedge clk);
        check_value("dbg_done", dbg_done, 1'b1);
        check_value("f2e.instr", f2e.instr, NOP_WORD);
        next_cycle();
        dbg.exit_request = 1'b1;
        @(negedge clk);
        check_value("dbg_done", dbg_done, 1'b0);
        check_value("f2e.instr", f2e.instr, NOP_WORD);
        next_cycle();
        @(negedge clk);
        check_value("dbg_mode", dbg_mode, 1'b0);
        exp_pc = BASE + 32'h30;
        wait_done();
        take_word();
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Run ended: %0d checks, %0d errors", checks, errors);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        void'($urandom(85058));
        errors  = 0;
        checks  = 0;
        rst_n   = 1'b0;
        exp_pc  = '0;
        last_pc = '0;
        csr     = '{mtvec: MTVEC, stvec: STVEC, cur_priv: PRIV_MACHINE, medeleg: 16'h0002};
        irq     = '0;
        dbg     = '0;
        e2f     = '0;
        e2f.ready = 1'b1;
        $readmemh("bench/program.hex", model);

        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        sequential_fetch();
        backpressure_order();
        branch_and_flush();
        fetch_faults();
        irq_and_bubble_branch();
        debug_halt_resume();

        $display("Run ended: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+hw
hw/mem_if_pkg.sv
hw/core_pkg.sv
hw/trap_target.sv
hw/fetch_unit.sv
hw/instr_mem_port.sv
hw/fetch_subsystem.sv
bench/fetch_tb.sv

// File: bench/program.hex
// One 32-bit instruction word per line in hex, first line is the word at MEM_BASE
// Each word is addi x1, x0, n with n counting up from 1
00100093
00200093
00300093
00400093
00500093
00600093
00700093
00800093
00900093
00a00093
00b00093
00c00093
00d00093
00e00093
00f00093
01000093
01100093
01200093
01300093
01400093
01500093
01600093
01700093
01800093
01900093
01a00093
01b00093
01c00093
01d00093
01e00093
01f00093
02000093
02100093
02200093
02300093
02400093
02500093
02600093
02700093
02800093
02900093
02a00093
02b00093
02c00093
02d00093
02e00093
02f00093
03000093
03100093
03200093
03300093
03400093
03500093
03600093
03700093
03800093
03900093
03a00093
03b00093
03c00093
03d00093
03e00093
03f00093
04000093
